// File: raycast_cfg.svh
`ifndef RAYCAST_CFG_SVH
`define RAYCAST_CFG_SVH

// **********************************************************************
// screen sweep
// **********************************************************************

// ray columns per sweep
`define SCREEN_COLS 320
// enough bits for column 0..319
`define COL_W 9

// ray fifo entries
`define FIFO_DEPTH 16

// **********************************************************************
// movement and camera
// **********************************************************************

// one move step is dir >>> 2, a quarter tile
`define MOVE_SHIFT 2
// approx 256 * 2 / 320 in 8.8 steps
`define CAM_SCALE 410

// reset pose in 8.8, pos at 11.5/11.5 facing +x
`define RST_POS_X 16'h0B80
`define RST_POS_Y 16'h0B80
`define RST_DIR_X 16'h0100
`define RST_DIR_Y 16'h0000
`define RST_PLANE_X 16'h0000
`define RST_PLANE_Y 16'h00A9

`endif

// File: raycast_pkg.sv
`include "raycast_cfg.svh"

package raycast_pkg;

    // **********************************************************************
    // fixed point and pose
    // **********************************************************************

    // signed 8.8 word
    typedef logic signed [15:0] fix16_t;

    // player pose, all 8.8
    typedef struct packed {
        fix16_t pos_x;
        fix16_t pos_y;
        fix16_t dir_x;
        fix16_t dir_y;
        fix16_t plane_x;
        fix16_t plane_y;
    } pose_t;

    // movement buttons, active high levels
    typedef struct packed {
        logic rot_left;
        logic rot_right;
        logic fwd;
        logic bwd;
    } btn_t;

    // **********************************************************************
    // ray record
    // **********************************************************************

    // step bit set means the ray steps toward negative
    typedef struct packed {
        logic [`COL_W-1:0] column;
        fix16_t            ray_dir_x;
        fix16_t            ray_dir_y;
        logic              step_x;
        logic              step_y;
        logic              last;
    } ray_t;

endpackage

// File: pose_regs.sv
`timescale 1ns/1ns
`include "raycast_cfg.svh"

module pose_regs (
    input  logic               clk_pixel,
    input  logic               sys_rst,
    input  logic               frame_start,
    input  raycast_pkg::btn_t  btn,
    output raycast_pkg::pose_t pose,
    output logic               pose_strobe
);
    import raycast_pkg::*;

    // pose loaded on reset
    localparam pose_t RST_POSE = '{
        pos_x:   `RST_POS_X,
        pos_y:   `RST_POS_Y,
        dir_x:   `RST_DIR_X,
        dir_y:   `RST_DIR_Y,
        plane_x: `RST_PLANE_X,
        plane_y: `RST_PLANE_Y
    };

    pose_t  pose_nxt;
    fix16_t move_x;
    fix16_t move_y;

    // one move step along dir
    assign move_x = pose.dir_x >>> `MOVE_SHIFT;
    assign move_y = pose.dir_y >>> `MOVE_SHIFT;

    // **********************************************************************
    // button action, first pressed wins
    // **********************************************************************

    always_comb begin
        pose_nxt = pose;
        if (btn.rot_left) begin
            // +90 deg, (x,y) -> (-y,x)
            pose_nxt.dir_x   = -pose.dir_y;
            pose_nxt.dir_y   = pose.dir_x;
            pose_nxt.plane_x = -pose.plane_y;
            pose_nxt.plane_y = pose.plane_x;
        end else if (btn.rot_right) begin
            // -90 deg, (x,y) -> (y,-x)
            pose_nxt.dir_x   = pose.dir_y;
            pose_nxt.dir_y   = -pose.dir_x;
            pose_nxt.plane_x = pose.plane_y;
            pose_nxt.plane_y = -pose.plane_x;
        end else if (btn.fwd) begin
            pose_nxt.pos_x = pose.pos_x + move_x;
            pose_nxt.pos_y = pose.pos_y + move_y;
        end else if (btn.bwd) begin
            pose_nxt.pos_x = pose.pos_x - move_x;
            pose_nxt.pos_y = pose.pos_y - move_y;
        end
    end

    // **********************************************************************
    // pose registers
    // **********************************************************************

    // pose and strobe land together one cycle after frame_start
    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            pose        <= RST_POSE;
            pose_strobe <= 1'b0;
        end else begin
            pose_strobe <= frame_start;
            if (frame_start) begin
                pose <= pose_nxt;
            end
        end
    end

    // frames are far apart, so back-to-back updates mean a broken frame pulse
    assert property (@(posedge clk_pixel) disable iff (sys_rst)
        pose_strobe |=> !pose_strobe);

endmodule

// File: ray_setup.sv
`timescale 1ns/1ns
`include "raycast_cfg.svh"

module ray_setup (
    input  logic               clk_pixel,
    input  logic               sys_rst,
    input  raycast_pkg::pose_t pose,
    input  logic               pose_strobe,
    output logic               setup_valid,
    output raycast_pkg::ray_t  setup_ray,
    input  logic               setup_ready
);
    import raycast_pkg::*;

    localparam logic [`COL_W-1:0] LAST_COL = `COL_W'(`SCREEN_COLS - 1);

    // sweep state
    logic              active;
    logic [`COL_W-1:0] col;
    pose_t             snap;

    // pipeline flow
    logic issue;
    logic s1_ready;
    logic s2_ready;

    // stage 1 regs
    logic              s1_valid;
    logic [`COL_W-1:0] s1_col;
    fix16_t            s1_dir_x;
    fix16_t            s1_dir_y;
    logic signed [31:0] s1_prod_x;
    logic signed [31:0] s1_prod_y;

    // stage 1 comb
    logic [17:0]        col_scaled;
    fix16_t             cam;
    logic signed [31:0] prod_x;
    logic signed [31:0] prod_y;

    // stage 2 comb
    fix16_t dir_sum_x;
    fix16_t dir_sum_y;

    // a stage moves when the one after it is empty or draining
    assign s2_ready = !setup_valid || setup_ready;
    assign s1_ready = !s1_valid || s2_ready;
    assign issue    = active && s1_ready;

    // **********************************************************************
    // column sweep
    // **********************************************************************

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            active <= 1'b0;
            col    <= '0;
        end else if (!active) begin
            // strobes during a sweep are dropped
            if (pose_strobe) begin
                active <= 1'b1;
                col    <= '0;
            end
        end else if (issue) begin
            if (col == LAST_COL) begin
                active <= 1'b0;
                col    <= '0;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // pose held for the whole sweep
    always_ff @(posedge clk_pixel) begin
        if (!active && pose_strobe) begin
            snap <= pose;
        end
    end

    // **********************************************************************
    // stage 1, camera term and plane products
    // **********************************************************************

    // cam = ((c * scale) >> 8) - 256, runs -1.0 .. ~+1.0
    assign col_scaled = col * 18'(`CAM_SCALE);
    assign cam        = $signed({6'd0, col_scaled[17:8]}) - 16'sd256;
    assign prod_x     = snap.plane_x * cam;
    assign prod_y     = snap.plane_y * cam;

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            s1_valid <= 1'b0;
        end else if (s1_ready) begin
            s1_valid <= issue;
        end
    end

    // dir travels along so a new snapshot cannot reach older columns
    always_ff @(posedge clk_pixel) begin
        if (issue) begin
            s1_col    <= col;
            s1_dir_x  <= snap.dir_x;
            s1_dir_y  <= snap.dir_y;
            s1_prod_x <= prod_x;
            s1_prod_y <= prod_y;
        end
    end

    // **********************************************************************
    // stage 2, direction sum and step signs
    // **********************************************************************

    // bits 23:8 are the product >>> 8 cut to 16 bits
    assign dir_sum_x = s1_dir_x + fix16_t'(s1_prod_x[23:8]);
    assign dir_sum_y = s1_dir_y + fix16_t'(s1_prod_y[23:8]);

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            setup_valid <= 1'b0;
        end else if (s2_ready) begin
            setup_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (s1_valid && s2_ready) begin
            setup_ray.column    <= s1_col;
            setup_ray.ray_dir_x <= dir_sum_x;
            setup_ray.ray_dir_y <= dir_sum_y;
            // sign bit doubles as negative step
            setup_ray.step_x    <= dir_sum_x[15];
            setup_ray.step_y    <= dir_sum_y[15];
            setup_ray.last      <= (s1_col == LAST_COL);
        end
    end

    // held ray must not change under back-pressure from the fifo
    assert property (@(posedge clk_pixel) disable iff (sys_rst)
        setup_valid && !setup_ready |=> $stable(setup_ray));

endmodule

// File: ray_fifo.sv
`timescale 1ns/1ns
`include "raycast_cfg.svh"

module ray_fifo (
    input  logic              clk_pixel,
    input  logic              sys_rst,
    input  logic              in_valid,
    output logic              in_ready,
    input  raycast_pkg::ray_t in_ray,
    output logic              out_valid,
    input  logic              out_ready,
    output raycast_pkg::ray_t out_ray
);
    import raycast_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    ray_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // full blocks pushes even when popping
    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_ray   = mem[rd_ptr];

    // **********************************************************************
    // storage and pointers
    // **********************************************************************

    always_ff @(posedge clk_pixel) begin
        if (push) begin
            mem[wr_ptr] <= in_ray;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk_pixel) disable iff (sys_rst)
        count <= CNT_W'(DEPTH));

    // a pop needs the pointers to agree that an entry is stored
    assert property (@(posedge clk_pixel) disable iff (sys_rst)
        pop |-> (rd_ptr != wr_ptr) || (count == CNT_W'(DEPTH)));

endmodule

// File: raycast_front.sv
`timescale 1ns/1ns
`include "raycast_cfg.svh"

module raycast_front (
    input  logic               clk_pixel,
    input  logic               sys_rst,
    input  logic               frame_start,
    input  raycast_pkg::btn_t  btn,
    output logic               ray_valid,
    input  logic               ray_ready,
    output raycast_pkg::ray_t  ray,
    output raycast_pkg::pose_t pose
);
    import raycast_pkg::*;

    // pose block to ray setup
    logic pose_strobe;

    // ray setup to fifo
    logic setup_valid;
    logic setup_ready;
    ray_t setup_ray;

    // **********************************************************************
    // pose -> ray setup -> fifo -> consumer
    // **********************************************************************

    pose_regs pose_regs_inst (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .frame_start (frame_start),
        .btn         (btn),
        .pose        (pose),
        .pose_strobe (pose_strobe)
    );

    ray_setup ray_setup_inst (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .pose        (pose),
        .pose_strobe (pose_strobe),
        .setup_valid (setup_valid),
        .setup_ray   (setup_ray),
        .setup_ready (setup_ready)
    );

    // consumer side may stall, fifo soaks it up
    ray_fifo ray_fifo_inst (
        .clk_pixel (clk_pixel),
        .sys_rst   (sys_rst),
        .in_valid  (setup_valid),
        .in_ready  (setup_ready),
        .in_ray    (setup_ray),
        .out_valid (ray_valid),
        .out_ready (ray_ready),
        .out_ray   (ray)
    );

endmodule

// File: tb_raycast_front.sv
`timescale 1ns/1ns
`include "raycast_cfg.svh"

module tb_raycast_front;
    import raycast_pkg::*;

    localparam int NUM_ROWS = 16;
    localparam int COLS     = `SCREEN_COLS;
    // four cycles per ray covers a 60 % stall plus reset and frame gaps
    localparam int CYCLE_LIMIT = NUM_ROWS * COLS * 4 + 2000;

    localparam pose_t HOME_POSE = '{
        pos_x:   `RST_POS_X,
        pos_y:   `RST_POS_Y,
        dir_x:   `RST_DIR_X,
        dir_y:   `RST_DIR_Y,
        plane_x: `RST_PLANE_X,
        plane_y: `RST_PLANE_Y
    };

    logic  clk_pixel;
    logic  sys_rst;
    logic  frame_start;
    btn_t  btn;
    logic  ray_valid;
    logic  ray_ready;
    ray_t  ray;
    pose_t pose;

    // **********************************************************************
    // stimulus table with btn bits as {rot_left, rot_right, fwd, bwd}
    // **********************************************************************

    string row_name [NUM_ROWS] = '{
        "idle", "fwd", "bwd", "rotl_1", "rotl_2", "rotl_3", "rotl_4", "rotr_1",
        "rotr_2", "rotr_3", "rotr_4", "prio_all", "prio_rr_fwd", "prio_fwd_bwd",
        "stall_60", "stall_bwd"
    };
    btn_t row_btn [NUM_ROWS] = '{
        4'b0000, 4'b0010, 4'b0001, 4'b1000, 4'b1000, 4'b1000, 4'b1000, 4'b0100,
        4'b0100, 4'b0100, 4'b0100, 4'b1111, 4'b0111, 4'b0011, 4'b0000, 4'b0001
    };
    // percent of cycles with ready low
    int row_stall [NUM_ROWS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 30, 0, 0, 0, 60, 60};

    pose_t       model;
    ray_t        prev_rays [COLS];
    ray_t        cur_rays [COLS];
    logic [31:0] lcg_state;
    int          value_errs;
    int          other_errs;

    raycast_front raycast_front_inst (
        .clk_pixel   (clk_pixel),
        .sys_rst     (sys_rst),
        .frame_start (frame_start),
        .btn         (btn),
        .ray_valid   (ray_valid),
        .ray_ready   (ray_ready),
        .ray         (ray),
        .pose        (pose)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #10 clk_pixel = ~clk_pixel;
    end

    // **********************************************************************
    // reference model
    // **********************************************************************

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // first pressed button wins and turns are 90 deg
    function automatic pose_t apply_button(input pose_t p, input btn_t b);
        pose_t n;
        n = p;
        if (b.rot_left) begin
            n.dir_x   = -p.dir_y;
            n.dir_y   = p.dir_x;
            n.plane_x = -p.plane_y;
            n.plane_y = p.plane_x;
        end else if (b.rot_right) begin
            n.dir_x   = p.dir_y;
            n.dir_y   = -p.dir_x;
            n.plane_x = p.plane_y;
            n.plane_y = -p.plane_x;
        end else if (b.fwd) begin
            n.pos_x = p.pos_x + (p.dir_x >>> `MOVE_SHIFT);
            n.pos_y = p.pos_y + (p.dir_y >>> `MOVE_SHIFT);
        end else if (b.bwd) begin
            n.pos_x = p.pos_x - (p.dir_x >>> `MOVE_SHIFT);
            n.pos_y = p.pos_y - (p.dir_y >>> `MOVE_SHIFT);
        end
        return n;
    endfunction

    // camera offset in 8.8 then plane scaled onto dir
    function automatic ray_t expected_ray(input pose_t p, input int c);
        ray_t r;
        int   cam;
        int   prod_x;
        int   prod_y;
        cam         = ((c * `CAM_SCALE) >> 8) - 256;
        prod_x      = int'(p.plane_x) * cam;
        prod_y      = int'(p.plane_y) * cam;
        r.column    = `COL_W'(c);
        r.ray_dir_x = p.dir_x + fix16_t'(prod_x >>> 8);
        r.ray_dir_y = p.dir_y + fix16_t'(prod_y >>> 8);
        r.step_x    = r.ray_dir_x[15];
        r.step_y    = r.ray_dir_y[15];
        r.last      = (c == COLS - 1);
        return r;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        if (expected !== actual) begin
            value_errs++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // **********************************************************************
    // frame pulse and ray collection
    // **********************************************************************

    // returns one negedge after pose_strobe's cycle
    task automatic pulse_frame(input btn_t b);
        @(negedge clk_pixel);
        btn         = b;
        frame_start = 1'b1;
        @(negedge clk_pixel);
        frame_start = 1'b0;
        btn         = '0;
        @(negedge clk_pixel);
    endtask

    // ready set at negedge so the transfer lands on the next posedge
    task automatic collect_sweep(input string name, input int stall, output int n);
        logic ready;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            ready = 1'b1;
            if (stall > 0) begin
                lcg_state = lcg_next(lcg_state);
                ready     = (((lcg_state >> 16) % 100) >= stall);
            end
            ray_ready = ready;
            if (ray_valid && ready) begin
                cur_rays[n] = ray;
                compare_value($sformatf("%s col %0d", name, n),
                              128'(expected_ray(model, n)), 128'(ray));
                n++;
                if (ray.last) begin
                    done = 1'b1;
                end else if (n == COLS) begin
                    other_errs++;
                    $display("no last flag after %0d rays in %s", COLS, name);
                    done = 1'b1;
                end
            end
            @(negedge clk_pixel);
        end
        ray_ready = 1'b0;
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************

    initial begin
        int n;
        sys_rst     = 1'b1;
        frame_start = 1'b0;
        btn         = '0;
        ray_ready   = 1'b0;
        lcg_state   = 32'h5b79_7723;
        value_errs  = 0;
        other_errs  = 0;
        model       = HOME_POSE;
        // reset seen on 16 rising edges, released on the falling edge after
        repeat (16) @(posedge clk_pixel);
        @(negedge clk_pixel);
        sys_rst = 1'b0;
        compare_value("reset pose", 128'(model), 128'(pose));
        compare_value("reset ray_valid", 128'(1'b0), 128'(ray_valid));

        for (int i = 0; i < NUM_ROWS; i++) begin
            prev_rays = cur_rays;
            pulse_frame(row_btn[i]);
            model = apply_button(model, row_btn[i]);
            compare_value($sformatf("%s pose", row_name[i]), 128'(model), 128'(pose));
            collect_sweep(row_name[i], row_stall[i], n);
            compare_value($sformatf("%s ray count", row_name[i]), 128'(COLS), 128'(n));
            // unchanged pose means the sweep repeats the one before
            if (i > 0 && row_btn[i] == '0) begin
                for (int c = 0; c < COLS; c++) begin
                    compare_value($sformatf("%s repeat col %0d", row_name[i], c),
                                  128'(prev_rays[c]), 128'(cur_rays[c]));
                end
            end
        end

        // every move and turn in the table is undone later
        compare_value("final pose home", 128'(HOME_POSE), 128'(pose));
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // hang guard
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk_pixel);
            cycles++;
        end
        $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+.
raycast_pkg.sv
pose_regs.sv
ray_setup.sv
ray_fifo.sv
raycast_front.sv
tb_raycast_front.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --assert -Wno-fatal
TOP      = tb_raycast_front
FILELIST = build.f
OBJ_DIR  = obj_dir

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST)) raycast_cfg.svh

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
